// ==== hw/xosvm_csr_bank.sv ====
`timescale 1ns/1ps

`include "xosvm_defines.svh"

module xosvm_csr_bank
    import xosvm_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n_i,

    input  logic                         csr_we_i,
    input  logic [`XOSVM_CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [`XOSVM_XLEN-1:0]       csr_wdata_i,
    output logic [`XOSVM_XLEN-1:0]       csr_rdata_o,

    output logic                         mvmctl_o,
    output mmu_window_t                  inst_window_o,
    output mmu_window_t                  data_window_o
);

    // Offset zero, size and mask fully open
    localparam mmu_window_t WINDOW_RESET = '{
        offset: '0,
        size:   `XOSVM_SIZE_RESET,
        mask:   `XOSVM_MASK_RESET
    };

////////////////////////////////////////////////////////////////////////////
// Registers
////////////////////////////////////////////////////////////////////////////

    logic        mvmctl_q;
    mmu_window_t inst_win_q;
    mmu_window_t data_win_q;

    // Only bit 0 of mvmctl is implemented
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mvmctl_q   <= 1'b0;
            inst_win_q <= WINDOW_RESET;
            data_win_q <= WINDOW_RESET;
        end
        else if (csr_we_i) begin
            case (csr_addr_i)
                `XOSVM_CSR_MVMCTL: begin
                    mvmctl_q <= csr_wdata_i[0];
                end
                `XOSVM_CSR_MVMDO: begin
                    data_win_q.offset <= csr_wdata_i;
                end
                `XOSVM_CSR_MVMDS: begin
                    data_win_q.size <= csr_wdata_i;
                end
                `XOSVM_CSR_MVMDM: begin
                    data_win_q.mask <= csr_wdata_i;
                end
                `XOSVM_CSR_MVMIO: begin
                    inst_win_q.offset <= csr_wdata_i;
                end
                `XOSVM_CSR_MVMIS: begin
                    inst_win_q.size <= csr_wdata_i;
                end
                `XOSVM_CSR_MVMIM: begin
                    inst_win_q.mask <= csr_wdata_i;
                end
                default: begin
                    // Writes outside the range are dropped
                end
            endcase
        end
    end

////////////////////////////////////////////////////////////////////////////
// Read mux
////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (csr_addr_i)
            `XOSVM_CSR_MVMCTL: begin
                csr_rdata_o = {{(`XOSVM_XLEN-1){1'b0}}, mvmctl_q};
            end
            `XOSVM_CSR_MVMDO: begin
                csr_rdata_o = data_win_q.offset;
            end
            `XOSVM_CSR_MVMDS: begin
                csr_rdata_o = data_win_q.size;
            end
            `XOSVM_CSR_MVMDM: begin
                csr_rdata_o = data_win_q.mask;
            end
            `XOSVM_CSR_MVMIO: begin
                csr_rdata_o = inst_win_q.offset;
            end
            `XOSVM_CSR_MVMIS: begin
                csr_rdata_o = inst_win_q.size;
            end
            `XOSVM_CSR_MVMIM: begin
                csr_rdata_o = inst_win_q.mask;
            end
            default: begin
                csr_rdata_o = '0;
            end
        endcase
    end

////////////////////////////////////////////////////////////////////////////
// Window outputs
////////////////////////////////////////////////////////////////////////////

    assign mvmctl_o      = mvmctl_q;
    assign inst_window_o = inst_win_q;
    assign data_window_o = data_win_q;

endmodule

// ==== hw/xosvm_defines.svh ====
`ifndef XOSVM_DEFINES_SVH
`define XOSVM_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////

// Data and address width
`define XOSVM_XLEN        32
`define XOSVM_CSR_ADDR_W  12
// One enable per byte lane
`define XOSVM_WE_W        4

////////////////////////////////////////////////////////////////////////////
// Relocation CSR addresses (custom machine range)
////////////////////////////////////////////////////////////////////////////

`define XOSVM_CSR_MVMCTL  12'h7C0
`define XOSVM_CSR_MVMDO   12'h7C1
`define XOSVM_CSR_MVMDS   12'h7C2
`define XOSVM_CSR_MVMDM   12'h7C3
`define XOSVM_CSR_MVMIO   12'h7C4
`define XOSVM_CSR_MVMIS   12'h7C5
`define XOSVM_CSR_MVMIM   12'h7C6

// Masks and sizes come up fully open
`define XOSVM_MASK_RESET  {`XOSVM_XLEN{1'b1}}
`define XOSVM_SIZE_RESET  {`XOSVM_XLEN{1'b1}}

`endif

// ==== hw/xosvm_mmu.sv ====
`timescale 1ns/1ps

`include "xosvm_defines.svh"

module xosvm_mmu
    import xosvm_pkg::*;
(
    input  logic                   en_i,
    input  mmu_window_t            window_i,
    input  logic [`XOSVM_XLEN-1:0] addr_i,
    output logic [`XOSVM_XLEN-1:0] addr_o,
    output logic                   fault_o
);

////////////////////////////////////////////////////////////////////////////
// Relocation datapath
////////////////////////////////////////////////////////////////////////////

    logic [`XOSVM_XLEN-1:0] masked_addr;
    logic [`XOSVM_XLEN-1:0] relocated_addr;
    logic                   out_of_window;

    assign masked_addr = addr_i & window_i.mask;

    // Wraps modulo 2^XLEN, carry out is dropped
    assign relocated_addr = masked_addr + window_i.offset;

    // Bound check uses the address as issued, before masking
    assign out_of_window = (addr_i >= window_i.size);

////////////////////////////////////////////////////////////////////////////
// Output select
////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (en_i) begin
            addr_o  = relocated_addr;
            fault_o = out_of_window;
        end
        else begin
            // Bypass, no protection check
            addr_o  = addr_i;
            fault_o = 1'b0;
        end
    end

endmodule

// ==== hw/xosvm_pkg.sv ====
`include "xosvm_defines.svh"

package xosvm_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Privilege levels
    ////////////////////////////////////////////////////////////////////////////

    // Encoding 2'b10 is reserved
    typedef enum logic [1:0] {
        PRIV_USER       = 2'b00,
        PRIV_SUPERVISOR = 2'b01,
        PRIV_MACHINE    = 2'b11
    } privilege_e;

    ////////////////////////////////////////////////////////////////////////////
    // Shared bundles
    ////////////////////////////////////////////////////////////////////////////

    // One relocation window
    typedef struct packed {
        logic [`XOSVM_XLEN-1:0] offset;
        logic [`XOSVM_XLEN-1:0] size;
        logic [`XOSVM_XLEN-1:0] mask;
    } mmu_window_t;

    // Untranslated data request
    typedef struct packed {
        logic                   re;
        logic [`XOSVM_WE_W-1:0] we;
        logic [`XOSVM_XLEN-1:0] addr;
    } mem_req_t;

endpackage

// ==== hw/xosvm_top.sv ====
`timescale 1ns/1ps

`include "xosvm_defines.svh"

module xosvm_top
    import xosvm_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n_i,

    // CSR access
    input  logic                         csr_we_i,
    input  logic [`XOSVM_CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [`XOSVM_XLEN-1:0]       csr_wdata_i,
    output logic [`XOSVM_XLEN-1:0]       csr_rdata_o,

    input  privilege_e                   privilege_i,

    // Fetch side
    input  logic [`XOSVM_XLEN-1:0]       inst_addr_i,
    output logic [`XOSVM_XLEN-1:0]       inst_addr_o,
    output logic                         inst_fault_o,

    // Data side
    input  mem_req_t                     data_req_i,
    output logic [`XOSVM_XLEN-1:0]       mem_addr_o,
    output logic [`XOSVM_WE_W-1:0]       mem_we_o,
    output logic                         mem_op_en_o,
    output logic                         data_fault_o
);

////////////////////////////////////////////////////////////////////////////
// Internal signals
////////////////////////////////////////////////////////////////////////////

    logic        mvmctl;
    logic        mmu_en;
    mmu_window_t inst_window;
    mmu_window_t data_window;

    logic        data_fault;
    logic        mem_access;

////////////////////////////////////////////////////////////////////////////
// Relocation control registers
////////////////////////////////////////////////////////////////////////////

    xosvm_csr_bank u_csr_bank (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .csr_we_i      (csr_we_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .csr_rdata_o   (csr_rdata_o),
        .mvmctl_o      (mvmctl),
        .inst_window_o (inst_window),
        .data_window_o (data_window)
    );

    // Machine mode always sees physical addresses
    assign mmu_en = mvmctl && (privilege_i != PRIV_MACHINE);

////////////////////////////////////////////////////////////////////////////
// Fetch relocation
////////////////////////////////////////////////////////////////////////////

    xosvm_mmu u_i_mmu (
        .en_i     (mmu_en),
        .window_i (inst_window),
        .addr_i   (inst_addr_i),
        .addr_o   (inst_addr_o),
        .fault_o  (inst_fault_o)
    );

////////////////////////////////////////////////////////////////////////////
// Data relocation
////////////////////////////////////////////////////////////////////////////

    xosvm_mmu u_d_mmu (
        .en_i     (mmu_en),
        .window_i (data_window),
        .addr_i   (data_req_i.addr),
        .addr_o   (mem_addr_o),
        .fault_o  (data_fault)
    );

////////////////////////////////////////////////////////////////////////////
// Memory operation gating
////////////////////////////////////////////////////////////////////////////

    // Any load or any byte of a store
    assign mem_access = data_req_i.re || (|data_req_i.we);

    // A faulting access never reaches memory
    assign mem_op_en_o = mem_access && !data_fault;

    // Byte lanes go out as requested
    assign mem_we_o = data_req_i.we;

    assign data_fault_o = data_fault;

endmodule

// ==== list.f ====
+incdir+hw
hw/xosvm_pkg.sv
hw/xosvm_csr_bank.sv
hw/xosvm_mmu.sv
hw/xosvm_top.sv
testbench/tb_xosvm_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module tb_xosvm_top \
    && ./obj_dir/Vtb_xosvm_top > sim.log 2>&1 \
    || echo "build or simulation did not complete"

if [ -f sim.log ]; then
    cat sim.log
fi

grep -q "^Result: PASSED$" sim.log 2>/dev/null \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/tb_xosvm_top.sv ====
`timescale 1ns/1ps

`include "xosvm_defines.svh"

module tb_xosvm_top
    import xosvm_pkg::*;
();

    logic                         clk;
    logic                         rst_n_i;
    logic                         csr_we_i;
    logic [`XOSVM_CSR_ADDR_W-1:0] csr_addr_i;
    logic [`XOSVM_XLEN-1:0]       csr_wdata_i;
    logic [`XOSVM_XLEN-1:0]       csr_rdata_o;
    privilege_e                   privilege_i;
    logic [`XOSVM_XLEN-1:0]       inst_addr_i;
    logic [`XOSVM_XLEN-1:0]       inst_addr_o;
    logic                         inst_fault_o;
    mem_req_t                     data_req_i;
    logic [`XOSVM_XLEN-1:0]       mem_addr_o;
    logic [`XOSVM_WE_W-1:0]       mem_we_o;
    logic                         mem_op_en_o;
    logic                         data_fault_o;

    integer seed;
    integer errors;
    integer timeouts;
    integer checks;
    integer cycles_checked;
    logic   checking;
    string  test_name;

    // Reference copy of the relocation registers
    logic                   m_ctl;
    logic [`XOSVM_XLEN-1:0] m_do;
    logic [`XOSVM_XLEN-1:0] m_ds;
    logic [`XOSVM_XLEN-1:0] m_dm;
    logic [`XOSVM_XLEN-1:0] m_io;
    logic [`XOSVM_XLEN-1:0] m_is;
    logic [`XOSVM_XLEN-1:0] m_im;

    logic [`XOSVM_CSR_ADDR_W-1:0] csr_addrs [7];

    xosvm_top u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .csr_we_i     (csr_we_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_rdata_o  (csr_rdata_o),
        .privilege_i  (privilege_i),
        .inst_addr_i  (inst_addr_i),
        .inst_addr_o  (inst_addr_o),
        .inst_fault_o (inst_fault_o),
        .data_req_i   (data_req_i),
        .mem_addr_o   (mem_addr_o),
        .mem_we_o     (mem_we_o),
        .mem_op_en_o  (mem_op_en_o),
        .data_fault_o (data_fault_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

    function automatic logic [`XOSVM_XLEN-1:0] model_read(
        input logic [`XOSVM_CSR_ADDR_W-1:0] addr
    );
        case (addr)
            `XOSVM_CSR_MVMCTL: return {{(`XOSVM_XLEN-1){1'b0}}, m_ctl};
            `XOSVM_CSR_MVMDO:  return m_do;
            `XOSVM_CSR_MVMDS:  return m_ds;
            `XOSVM_CSR_MVMDM:  return m_dm;
            `XOSVM_CSR_MVMIO:  return m_io;
            `XOSVM_CSR_MVMIS:  return m_is;
            `XOSVM_CSR_MVMIM:  return m_im;
            default:           return '0;
        endcase
    endfunction

    task automatic check_value(
        input string                  what,
        input logic [`XOSVM_XLEN-1:0] expected,
        input logic [`XOSVM_XLEN-1:0] actual
    );
        checks = checks + 1;
        assert (expected === actual) else begin
            $display("mismatch %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            errors = errors + 1;
        end
    endtask

    // Outputs are settled since the falling edge, so the rising edge sees them stable
    always @(posedge clk) begin
        logic                   en;
        logic [`XOSVM_XLEN-1:0] exp_iaddr;
        logic [`XOSVM_XLEN-1:0] exp_daddr;
        logic                   exp_ifault;
        logic                   exp_dfault;
        logic                   exp_op_en;
        if (rst_n_i && checking) begin
            en         = m_ctl && (privilege_i != PRIV_MACHINE);
            exp_iaddr  = en ? ((inst_addr_i & m_im) + m_io) : inst_addr_i;
            exp_ifault = en && (inst_addr_i >= m_is);
            exp_daddr  = en ? ((data_req_i.addr & m_dm) + m_do) : data_req_i.addr;
            exp_dfault = en && (data_req_i.addr >= m_ds);
            exp_op_en  = (data_req_i.re || (|data_req_i.we)) && !exp_dfault;

            check_value("csr_rdata_o", model_read(csr_addr_i), csr_rdata_o);
            check_value("inst_addr_o", exp_iaddr, inst_addr_o);
            check_value("inst_fault_o", {31'b0, exp_ifault}, {31'b0, inst_fault_o});
            check_value("mem_addr_o", exp_daddr, mem_addr_o);
            check_value("data_fault_o", {31'b0, exp_dfault}, {31'b0, data_fault_o});
            check_value("mem_op_en_o", {31'b0, exp_op_en}, {31'b0, mem_op_en_o});
            check_value("mem_we_o", {28'b0, data_req_i.we}, {28'b0, mem_we_o});

            // Register update takes effect after this edge
            if (csr_we_i) begin
                case (csr_addr_i)
                    `XOSVM_CSR_MVMCTL: m_ctl = csr_wdata_i[0];
                    `XOSVM_CSR_MVMDO:  m_do  = csr_wdata_i;
                    `XOSVM_CSR_MVMDS:  m_ds  = csr_wdata_i;
                    `XOSVM_CSR_MVMDM:  m_dm  = csr_wdata_i;
                    `XOSVM_CSR_MVMIO:  m_io  = csr_wdata_i;
                    `XOSVM_CSR_MVMIS:  m_is  = csr_wdata_i;
                    `XOSVM_CSR_MVMIM:  m_im  = csr_wdata_i;
                    default: begin
                    end
                endcase
            end
            cycles_checked = cycles_checked + 1;
        end
    end

////////////////////////////////////////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////////////////////////////////////////

    task automatic random_request(output mem_req_t r);
        logic [31:0] bits;
        bits   = $random(seed);
        r.re   = bits[0];
        r.we   = bits[4:1];
        r.addr = $random(seed);
    endtask

    task automatic apply_cycle(
        input logic                         we,
        input logic [`XOSVM_CSR_ADDR_W-1:0] addr,
        input logic [`XOSVM_XLEN-1:0]       wdata,
        input privilege_e                   priv,
        input logic [`XOSVM_XLEN-1:0]       iaddr,
        input mem_req_t                     req
    );
        @(negedge clk);
        csr_we_i    = we;
        csr_addr_i  = addr;
        csr_wdata_i = wdata;
        privilege_i = priv;
        inst_addr_i = iaddr;
        data_req_i  = req;
    endtask

    task automatic csr_write(
        input logic [`XOSVM_CSR_ADDR_W-1:0] addr,
        input logic [`XOSVM_XLEN-1:0]       wdata
    );
        mem_req_t req;
        random_request(req);
        apply_cycle(1'b1, addr, wdata, PRIV_MACHINE, $random(seed), req);
    endtask

    task automatic wait_checked_cycles(input integer n);
        integer target;
        integer waited;
        target = cycles_checked + n;
        waited = 0;
        while (cycles_checked < target && waited < 10 * n + 10) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (cycles_checked < target) begin
            $display("timeout in %s: checker stopped advancing after %0d cycles",
                     test_name, waited);
            timeouts = timeouts + 1;
        end
    endtask

////////////////////////////////////////////////////////////////////////////
// Test sequence
////////////////////////////////////////////////////////////////////////////

    initial begin
        mem_req_t    req;
        logic [31:0] rnd;
        seed        = 32'h234cf765;
        errors      = 0;
        timeouts    = 0;
        checks      = 0;
        cycles_checked = 0;
        checking    = 1'b0;
        test_name   = "reset";
        rst_n_i     = 1'b0;
        csr_we_i    = 1'b0;
        csr_addr_i  = '0;
        csr_wdata_i = '0;
        privilege_i = PRIV_MACHINE;
        inst_addr_i = '0;
        data_req_i  = '0;
        csr_addrs   = '{`XOSVM_CSR_MVMCTL, `XOSVM_CSR_MVMDO, `XOSVM_CSR_MVMDS,
                        `XOSVM_CSR_MVMDM, `XOSVM_CSR_MVMIO, `XOSVM_CSR_MVMIS,
                        `XOSVM_CSR_MVMIM};
        m_ctl = 1'b0;
        m_do  = '0;
        m_io  = '0;
        m_ds  = `XOSVM_SIZE_RESET;
        m_is  = `XOSVM_SIZE_RESET;
        m_dm  = `XOSVM_MASK_RESET;
        m_im  = `XOSVM_MASK_RESET;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n_i  = 1'b1;
        checking = 1'b1;

        // Reset values, passthrough and request enables
        test_name = "reset_state";
        for (int i = 0; i < 14; i++) begin
            random_request(req);
            apply_cycle(1'b0, csr_addrs[i % 7], '0, (i % 2 == 0) ? PRIV_USER : PRIV_MACHINE,
                        $random(seed), req);
        end
        wait_checked_cycles(1);

        // Write then read back each register
        test_name = "csr_access";
        for (int i = 0; i < 7; i++) begin
            csr_write(csr_addrs[i], $random(seed));
            random_request(req);
            apply_cycle(1'b0, csr_addrs[i], '0, PRIV_MACHINE, $random(seed), req);
        end
        csr_write(`XOSVM_CSR_MVMCTL, 32'hFFFF_FFFF);
        apply_cycle(1'b0, `XOSVM_CSR_MVMCTL, '0, PRIV_MACHINE, '0, req);
        csr_write(12'h7C7, $random(seed));
        apply_cycle(1'b0, 12'h7C7, '0, PRIV_MACHINE, '0, req);
        csr_write(12'h000, $random(seed));
        apply_cycle(1'b0, 12'h000, '0, PRIV_MACHINE, '0, req);
        wait_checked_cycles(1);

        // Small windows, each mask narrower than its size
        csr_write(`XOSVM_CSR_MVMCTL, 32'h1);
        csr_write(`XOSVM_CSR_MVMDM, 32'h0000_0FFF);
        csr_write(`XOSVM_CSR_MVMDS, 32'h0001_0000);
        csr_write(`XOSVM_CSR_MVMDO, $random(seed));
        csr_write(`XOSVM_CSR_MVMIM, 32'h0000_FFFF);
        csr_write(`XOSVM_CSR_MVMIS, 32'h0004_0000);
        csr_write(`XOSVM_CSR_MVMIO, $random(seed));

        test_name = "machine_bypass";
        for (int i = 0; i < 20; i++) begin
            random_request(req);
            apply_cycle(1'b0, csr_addrs[i % 7], '0, PRIV_MACHINE, $random(seed), req);
        end
        wait_checked_cycles(1);

        // First pass uses the last address inside each window
        test_name = "user_relocation";
        for (int i = 0; i < 30; i++) begin
            random_request(req);
            req.addr = (i == 0) ? 32'h0000_FFFF : (req.addr & 32'h0000_FFFF);
            rnd = (i == 0) ? 32'hFFFF_FFFF : $random(seed);
            apply_cycle(1'b0, `XOSVM_CSR_MVMCTL, '0, (i % 3 == 2) ? PRIV_SUPERVISOR : PRIV_USER,
                        rnd & 32'h0003_FFFF, req);
        end
        wait_checked_cycles(1);

        // First pass of each loop hits the size exactly
        test_name = "protection_fault";
        for (int i = 0; i < 16; i++) begin
            rnd      = (i == 0) ? 32'h0 : $random(seed);
            req.re   = (i % 2 == 0);
            req.we   = (i % 2 == 0) ? 4'b0000 : (rnd[3:0] | 4'b0001);
            req.addr = 32'h0001_0000 + (rnd & 32'h0FFF_FFFF);
            apply_cycle(1'b0, `XOSVM_CSR_MVMDS, '0, PRIV_USER, rnd & 32'h0003_FFFF, req);
        end
        for (int i = 0; i < 16; i++) begin
            random_request(req);
            req.addr = req.addr & 32'h0000_FFFF;
            rnd = (i == 0) ? 32'h0 : $random(seed);
            apply_cycle(1'b0, `XOSVM_CSR_MVMIS, '0, PRIV_USER,
                        32'h0004_0000 + (rnd & 32'h0FFF_FFFF), req);
        end
        wait_checked_cycles(1);

        // Byte enables with translation toggling
        test_name = "we_passthrough";
        for (int i = 0; i < 32; i++) begin
            if (i % 8 == 0) begin
                csr_write(`XOSVM_CSR_MVMCTL, {31'b0, ((i / 8) % 2 == 1)});
            end
            else begin
                random_request(req);
                apply_cycle(1'b0, `XOSVM_CSR_MVMDO, '0, PRIV_USER, $random(seed), req);
            end
        end
        apply_cycle(1'b0, '0, '0, PRIV_MACHINE, '0, '0);
        wait_checked_cycles(2);

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end
        else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
